// File: verilog/fractal_consts.svh
// Mandelbrot engine constants.
// Float format fields, iteration limit and the widths of the tag,
// count and result queue.
`ifndef FRACTAL_CONSTS_SVH
`define FRACTAL_CONSTS_SVH

// Float word with sign, two's-complement exponent and explicit-one fraction.
`define FP_W      27
`define FP_SIGN   26
`define FP_EXP    25:18
`define FP_FRAC   17:0

// Iteration limit and the count that holds it.
`define MAX_ITER  64
`define CNT_W     7

`define TAG_W     8
`define RES_DEPTH 4

`endif

// File: verilog/fractal_pkg.sv
// Shared types of the Mandelbrot engine.
// Float word, point and result records, and the iterator FSM states.
`include "fractal_consts.svh"

package fractal_pkg;

    // Value is frac / 2^18 * 2^exp. A zero fraction means zero.
    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [17:0] frac;
    } fp27_t;

    // Complex point c = cx + i*cy with its tag.
    typedef struct packed {
        logic [`TAG_W-1:0] tag;
        fp27_t             cx;
        fp27_t             cy;
    } point_t;

    typedef struct packed {
        logic [`TAG_W-1:0] tag;
        logic [`CNT_W-1:0] count;
    } result_t;

    typedef enum logic [2:0] {
        IDLE,
        SQUARE,
        COMBINE,
        FINISH,
        CHECK,
        EMIT
    } iter_state_e;

endpackage

// File: verilog/fp_add.sv
// Two-stage float adder.
// Aligns and adds or subtracts in the first stage, then normalizes
// from the midway register and flushes underflow to zero.
`timescale 1ns/1ps
`include "fractal_consts.svh"

module fp_add (
    input  logic               iCLK,
    input  fractal_pkg::fp27_t a,
    input  fractal_pkg::fp27_t b,
    output fractal_pkg::fp27_t sum
);

    logic             a_s;
    logic [7:0]       a_e;
    logic [17:0]      a_f;
    logic             b_s;
    logic [7:0]       b_e;
    logic [17:0]      b_f;
    logic [8:0]       diff_a;
    logic [8:0]       diff_b;
    logic [7:0]       larger_exp;
    logic [36:0]      a_shift;
    logic [36:0]      b_shift;
    logic             a_larger;
    logic [36:0]      pre_sum;

    assign a_s = a[`FP_SIGN];
    assign a_e = a[`FP_EXP];
    assign a_f = a[`FP_FRAC];
    assign b_s = b[`FP_SIGN];
    assign b_e = b[`FP_EXP];
    assign b_f = b[`FP_FRAC];

    // Each sign-extended exponent difference is negative when its operand is larger.
    assign diff_a     = {b_e[7], b_e} - {a_e[7], a_e};
    assign diff_b     = {a_e[7], a_e} - {b_e[7], b_e};
    assign larger_exp = diff_b[8] ? b_e : a_e;

    // The smaller operand shifts right; far-apart operands drop out.
    assign a_shift = diff_a[8]         ? {1'b0, a_f, 18'b0} :
                     (diff_a > 9'd35)  ? 37'b0 :
                     ({1'b0, a_f, 18'b0} >> diff_a);
    assign b_shift = diff_b[8]         ? {1'b0, b_f, 18'b0} :
                     (diff_b > 9'd35)  ? 37'b0 :
                     ({1'b0, b_f, 18'b0} >> diff_b);

    assign a_larger = diff_a[8] | (~diff_b[8] & (a_f > b_f));

    // Subtract the smaller magnitude from the larger when the signs differ.
    assign pre_sum = ((a_s ^ b_s) &  a_larger) ? a_shift - b_shift :
                     ((a_s ^ b_s) & ~a_larger) ? b_shift - a_shift :
                     a_shift + b_shift;

    logic [36:0]        buf_pre_sum;
    logic [7:0]         buf_larger_exp;
    logic               buf_a_zero;
    logic               buf_b_zero;
    fractal_pkg::fp27_t buf_a;
    fractal_pkg::fp27_t buf_b;
    logic               buf_sign;

    always_ff @(posedge iCLK) begin
        buf_pre_sum    <= pre_sum;
        buf_larger_exp <= larger_exp;
        buf_a_zero     <= (a_f == 18'b0);
        buf_b_zero     <= (b_f == 18'b0);
        buf_a          <= a;
        buf_b          <= b;
        buf_sign       <= a_larger ? a_s : b_s;
    end

    // The leading-one search gives 37 when the sum is zero.
    logic [7:0] shift;

    always_comb begin
        shift = 8'd37;
        for (int i = 0; i <= 36; i++) begin
            if (buf_pre_sum[i]) begin
                shift = 8'(36 - i);
            end
        end
    end

    logic [53:0]      shifted;
    logic [17:0]      sum_f;
    logic [7:0]       sum_e;
    logic             underflow;
    logic [`FP_W-1:0] packed_sum;

    assign shifted = {buf_pre_sum, 17'b0} << shift;
    assign sum_f   = shifted[53:36];
    assign sum_e   = buf_larger_exp - shift + 8'd1;

    // A negative exponent that wraps positive has underflowed.
    assign underflow  = ~sum_e[7] && buf_larger_exp[7] && (shift != 8'd0);
    assign packed_sum = {buf_sign, sum_e, sum_f};

    assign sum = buf_a_zero ? buf_b :
                 buf_b_zero ? buf_a :
                 ((buf_pre_sum == 37'b0) || underflow) ? '0 :
                 fractal_pkg::fp27_t'(packed_sum);

endmodule

// File: verilog/fp_mult.sv
// Registered float multiplier.
// Multiplies the fractions, normalizes by at most one place and
// flushes zero operands and underflow to zero.
`timescale 1ns/1ps

module fp_mult (
    input  logic               iCLK,
    input  fractal_pkg::fp27_t a,
    input  fractal_pkg::fp27_t b,
    output fractal_pkg::fp27_t product
);

    logic [35:0] frac_prod;
    logic [17:0] frac_norm;
    logic [9:0]  exp_sum;
    logic        sign;
    logic        zero_in;
    logic        underflow;

    assign frac_prod = a.frac * b.frac;
    assign sign      = a.sign ^ b.sign;

    // Both fractions lie in [0.5, 1), so the product needs at most one shift.
    assign frac_norm = frac_prod[35] ? frac_prod[35:18] : frac_prod[34:17];

    // Exponents add in ten bits so that an out-of-range sum shows.
    assign exp_sum = {{2{a.exp[7]}}, a.exp}
                   + {{2{b.exp[7]}}, b.exp}
                   - {9'd0, ~frac_prod[35]};

    assign zero_in = (a.frac == 18'd0) || (b.frac == 18'd0);

    // Below -128 when the top three bits disagree on a negative sum.
    assign underflow = exp_sum[9] && (exp_sum[8:7] != 2'b11);

    always_ff @(posedge iCLK) begin
        if (zero_in || underflow) begin
            product <= '0;
        end else begin
            product.sign <= sign;
            product.exp  <= exp_sum[7:0];
            product.frac <= frac_norm;
        end
    end

endmodule

// File: verilog/point_intake.sv
// Input skid buffer for points.
// Two entries with a registered ready, so the source sees no path from pt_ready.
`timescale 1ns/1ps

module point_intake (
    input  logic                iCLK,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_ready,
    input  fractal_pkg::point_t in_point,
    output logic                pt_valid,
    input  logic                pt_ready,
    output fractal_pkg::point_t pt_point
);

    logic                main_valid;
    logic                spare_valid;
    fractal_pkg::point_t main_pt;
    fractal_pkg::point_t spare_pt;

    assign pt_valid = main_valid;
    assign pt_point = main_pt;

    always_ff @(posedge iCLK) begin
        if (reset) begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
            in_ready    <= 1'b1;
        end else if (!main_valid || pt_ready) begin
            // Refill the freed main slot from the spare first.
            if (spare_valid) begin
                main_valid  <= 1'b1;
                spare_valid <= 1'b0;
                in_ready    <= 1'b1;
            end else begin
                main_valid <= in_valid;
            end
        end else if (in_valid && in_ready) begin
            spare_valid <= 1'b1;
            in_ready    <= 1'b0;
        end
    end

    always_ff @(posedge iCLK) begin
        if (!main_valid || pt_ready) begin
            main_pt <= spare_valid ? spare_pt : in_point;
        end
        if (in_ready && main_valid && !pt_ready) begin
            spare_pt <= in_point;
        end
    end

endmodule

// File: verilog/escape_iterator.sv
// Escape-time iterator.
// Runs z = z^2 + c for one point at a time on three multipliers and
// three adders, four cycles per step, and emits the tag with its count.
`timescale 1ns/1ps
`include "fractal_consts.svh"

module escape_iterator (
    input  logic                 iCLK,
    input  logic                 reset,
    input  logic                 pt_valid,
    output logic                 pt_ready,
    input  fractal_pkg::point_t  pt_point,
    output logic                 res_valid,
    input  logic                 res_ready,
    output fractal_pkg::result_t res_result
);

    localparam logic [`CNT_W-1:0] last_iter = `CNT_W'(`MAX_ITER - 1);

    fractal_pkg::iter_state_e state;
    logic [`CNT_W-1:0]        count;
    logic [`TAG_W-1:0]        tag;
    fractal_pkg::fp27_t       x;
    fractal_pkg::fp27_t       y;
    fractal_pkg::fp27_t       cx;
    fractal_pkg::fp27_t       cy;
    fractal_pkg::fp27_t       mag;
    fractal_pkg::fp27_t       new_y;

    fractal_pkg::fp27_t xx;
    fractal_pkg::fp27_t yy;
    fractal_pkg::fp27_t xy;
    fractal_pkg::fp27_t xy2;
    fractal_pkg::fp27_t neg_yy;
    fractal_pkg::fp27_t re_a;
    fractal_pkg::fp27_t re_b;
    fractal_pkg::fp27_t re_sum;
    fractal_pkg::fp27_t mag_sum;
    fractal_pkg::fp27_t im_sum;
    logic               escape;

    // Products of the current z are ready in COMBINE.
    fp_mult mul_xx (.iCLK(iCLK), .a(x), .b(x), .product(xx));
    fp_mult mul_yy (.iCLK(iCLK), .a(y), .b(y), .product(yy));
    fp_mult mul_xy (.iCLK(iCLK), .a(x), .b(y), .product(xy));

    assign neg_yy = '{sign: ~yy.sign, exp: yy.exp, frac: yy.frac};
    // Doubling is an exponent step; a zero product stays zero.
    assign xy2 = (xy.frac == 18'd0) ? xy :
                 '{sign: xy.sign, exp: xy.exp + 8'd1, frac: xy.frac};

    // The real-part adder runs twice with x^2 - y^2 in COMBINE and + cx in FINISH.
    assign re_a = (state == fractal_pkg::FINISH) ? re_sum : xx;
    assign re_b = (state == fractal_pkg::FINISH) ? cx : neg_yy;

    fp_add add_re (.iCLK(iCLK), .a(re_a), .b(re_b), .sum(re_sum));
    fp_add add_mag (.iCLK(iCLK), .a(xx), .b(yy), .sum(mag_sum));
    fp_add add_im (.iCLK(iCLK), .a(xy2), .b(cy), .sum(im_sum));

    // Above 4 means exponent over 3, or exponent 3 with more than half scale.
    assign escape = (mag.frac != 18'd0) &&
                    (($signed(mag.exp) > 8'sd3) ||
                     ((mag.exp == 8'd3) && (mag.frac > 18'h20000)));

    assign pt_ready   = (state == fractal_pkg::IDLE);
    assign res_valid  = (state == fractal_pkg::EMIT);
    assign res_result = '{tag: tag, count: count};

    always_ff @(posedge iCLK) begin
        if (reset) begin
            state <= fractal_pkg::IDLE;
            count <= '0;
        end else begin
            case (state)
                fractal_pkg::IDLE: begin
                    if (pt_valid) begin
                        count <= '0;
                        state <= fractal_pkg::SQUARE;
                    end
                end
                fractal_pkg::SQUARE:  state <= fractal_pkg::COMBINE;
                fractal_pkg::COMBINE: state <= fractal_pkg::FINISH;
                fractal_pkg::FINISH:  state <= fractal_pkg::CHECK;
                fractal_pkg::CHECK: begin
                    if (escape) begin
                        state <= fractal_pkg::EMIT;
                    end else begin
                        count <= count + 1'b1;
                        state <= (count == last_iter) ? fractal_pkg::EMIT
                                                      : fractal_pkg::SQUARE;
                    end
                end
                fractal_pkg::EMIT: begin
                    if (res_ready) begin
                        state <= fractal_pkg::IDLE;
                    end
                end
                default: state <= fractal_pkg::IDLE;
            endcase
        end
    end

    // Point load while idle; the last load before leaving IDLE is the accepted one.
    always_ff @(posedge iCLK) begin
        if (state == fractal_pkg::IDLE) begin
            x   <= '0;
            y   <= '0;
            cx  <= pt_point.cx;
            cy  <= pt_point.cy;
            tag <= pt_point.tag;
        end
        if (state == fractal_pkg::FINISH) begin
            mag   <= mag_sum;
            new_y <= im_sum;
        end
        if (state == fractal_pkg::CHECK) begin
            x <= re_sum;
            y <= new_y;
        end
    end

endmodule

// File: verilog/result_queue.sv
// Result FIFO on the output side.
// Circular buffer with an occupancy count; a full queue stalls the iterator.
`timescale 1ns/1ps
`include "fractal_consts.svh"

module result_queue (
    input  logic                 iCLK,
    input  logic                 reset,
    input  logic                 res_valid,
    output logic                 res_ready,
    input  fractal_pkg::result_t res_result,
    output logic                 out_valid,
    input  logic                 out_ready,
    output fractal_pkg::result_t out_result
);

    localparam int ptr_w = $clog2(`RES_DEPTH);
    localparam int occ_w = $clog2(`RES_DEPTH + 1);

    fractal_pkg::result_t mem [`RES_DEPTH];
    logic [ptr_w-1:0]     rd_ptr;
    logic [ptr_w-1:0]     wr_ptr;
    logic [occ_w-1:0]     occ;
    logic                 push;
    logic                 pop;

    assign res_ready  = (occ != occ_w'(`RES_DEPTH));
    assign out_valid  = (occ != '0);
    assign out_result = mem[rd_ptr];
    assign push       = res_valid && res_ready;
    assign pop        = out_valid && out_ready;

    always_ff @(posedge iCLK) begin
        if (push) begin
            mem[wr_ptr] <= res_result;
        end
    end

    always_ff @(posedge iCLK) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            occ    <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(`RES_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(`RES_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged.
            if (push && !pop) begin
                occ <= occ + 1'b1;
            end else if (pop && !push) begin
                occ <= occ - 1'b1;
            end
        end
    end

endmodule

// File: verilog/mandel_engine.sv
// Mandelbrot escape-time engine, top level.
// Points enter through the skid buffer, run through the iterator one at
// a time and leave in input order through the result FIFO.
`timescale 1ns/1ps

module mandel_engine (
    input  logic                 iCLK,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  fractal_pkg::point_t  in_point,
    output logic                 out_valid,
    input  logic                 out_ready,
    output fractal_pkg::result_t out_result
);

    logic                 pt_valid;
    logic                 pt_ready;
    fractal_pkg::point_t  pt_point;
    logic                 res_valid;
    logic                 res_ready;
    fractal_pkg::result_t res_result;

    point_intake intake0 (
        .iCLK     (iCLK),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_point (in_point),
        .pt_valid (pt_valid),
        .pt_ready (pt_ready),
        .pt_point (pt_point)
    );

    escape_iterator iter0 (
        .iCLK       (iCLK),
        .reset      (reset),
        .pt_valid   (pt_valid),
        .pt_ready   (pt_ready),
        .pt_point   (pt_point),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_result (res_result)
    );

    result_queue queue0 (
        .iCLK       (iCLK),
        .reset      (reset),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_result (res_result),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

endmodule

// File: verification/mandel_properties.sv
// Handshake and range assertions on the Mandelbrot engine ports.
`timescale 1ns/1ps
`include "fractal_consts.svh"

module mandel_properties (
    input logic                 iCLK,
    input logic                 reset,
    input logic                 in_valid,
    input logic                 in_ready,
    input fractal_pkg::point_t  in_point,
    input logic                 out_valid,
    input logic                 out_ready,
    input fractal_pkg::result_t out_result
);

    int failures = 0;

    // A raised valid waits for its transfer with steady data.
    in_hold: assert property (@(posedge iCLK) disable iff (reset)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_point)))
        else begin
            failures++;
            $error("in_valid dropped or in_point changed before its transfer");
        end

    out_hold: assert property (@(posedge iCLK) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_result)))
        else begin
            failures++;
            $error("out_valid dropped or out_result changed while stalled");
        end

    count_range: assert property (@(posedge iCLK) disable iff (reset)
        out_valid |-> (out_result.count <= `CNT_W'(`MAX_ITER)))
        else begin
            failures++;
            $error("out_result.count above the iteration limit");
        end

endmodule

// File: verification/mandel_checker.sv
// Result checker for the Mandelbrot engine.
// Records accepted points in order and compares each output transfer
// with an escape-time count worked out in real arithmetic.
`timescale 1ns/1ps
`include "fractal_consts.svh"

module mandel_checker (
    input  logic                 iCLK,
    input  logic                 reset,
    input  logic                 in_valid,
    input  logic                 in_ready,
    input  fractal_pkg::point_t  in_point,
    input  logic                 out_valid,
    input  logic                 out_ready,
    input  fractal_pkg::result_t out_result,
    output int                   error_count,
    output int                   result_count
);

    fractal_pkg::point_t pending [$];

    // Value is frac / 2^18 scaled by 2^exp with exp in two's complement.
    function automatic real to_real(fractal_pkg::fp27_t f);
        real v;
        int  e;
        int  i;
        v = $itor(f.frac) / 262144.0;
        e = int'($signed(f.exp));
        for (i = 0; i < e; i++) begin
            v = v * 2.0;
        end
        for (i = 0; i > e; i--) begin
            v = v / 2.0;
        end
        if (f.sign) begin
            v = -v;
        end
        return v;
    endfunction

    // Escape at step n when |z_n|^2 > 4 and stop at MAX_ITER otherwise.
    function automatic int escape_count(real cx, real cy);
        real x;
        real y;
        real x_next;
        int  n;
        x = 0.0;
        y = 0.0;
        for (n = 0; n < `MAX_ITER; n++) begin
            if (x * x + y * y > 4.0) begin
                return n;
            end
            x_next = x * x - y * y + cx;
            y      = 2.0 * x * y + cy;
            x      = x_next;
        end
        return `MAX_ITER;
    endfunction

    always @(posedge iCLK) begin : compare
        fractal_pkg::point_t p;
        logic [`CNT_W-1:0]   expected;
        if (reset) begin
            pending.delete();
            error_count  = 0;
            result_count = 0;
        end else begin
            if (out_valid && out_ready) begin
                result_count++;
                if (pending.size() == 0) begin
                    $display("result with tag %h arrived with no point pending",
                             out_result.tag);
                    error_count++;
                end else begin
                    p        = pending.pop_front();
                    expected = `CNT_W'(escape_count(to_real(p.cx), to_real(p.cy)));
                    if (out_result.tag !== p.tag) begin
                        $display("[ERROR] out_result.tag expected %h got %h",
                                 p.tag, out_result.tag);
                        error_count++;
                    end
                    if (out_result.count !== expected) begin
                        $display("[ERROR] out_result.count expected %h got %h (tag %h)",
                                 expected, out_result.count, p.tag);
                        error_count++;
                    end
                end
            end
            if (in_valid && in_ready) begin
                pending.push_back(in_point);
            end
        end
    end

endmodule

// File: verification/mandel_tb.sv
// Testbench top for the Mandelbrot engine.
// Clock, reset, point stimulus, output stalls, watchdog and final report.
`timescale 1ns/1ps
`include "fractal_consts.svh"

module mandel_tb;

    localparam int num_tests       = 9;
    localparam int num_points      = 2 * num_tests + 10;
    localparam int watchdog_cycles = num_points * (4 * `MAX_ITER + 20) + 1000;

    logic                 iCLK = 1'b0;
    logic                 reset;
    logic                 in_valid;
    logic                 in_ready;
    fractal_pkg::point_t  in_point;
    logic                 out_valid;
    logic                 out_ready;
    fractal_pkg::result_t out_result;
    int                   mismatches;
    int                   results;
    int                   other_errors;
    int                   stall_mode;
    int                   total_errors;
    logic [31:0]          rng;
    logic [31:0]          stall_rng;

    // Dyadic test points c = cx + i*cy whose orbits stay exact.
    real test_cx [num_tests] = '{0.0, -2.0, 0.0, 2.0, -2.0, 2.0, 1.0, 1.0, 0.5};
    real test_cy [num_tests] = '{0.0, 0.0, 1.0, 2.0, 2.0, 0.0, 1.0, 0.0, 0.0};

    mandel_engine dut0 (
        .iCLK       (iCLK),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_point   (in_point),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

    mandel_checker checker0 (
        .iCLK         (iCLK),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_point     (in_point),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_result   (out_result),
        .error_count  (mismatches),
        .result_count (results)
    );

    bind mandel_engine mandel_properties props0 (
        .iCLK       (iCLK),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_point   (in_point),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

    always #4 iCLK = ~iCLK;

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    // Normalizes |v| into [0.5, 1) so the fraction carries its leading one.
    function automatic fractal_pkg::fp27_t to_fp27(real v);
        fractal_pkg::fp27_t f;
        real                m;
        int                 e;
        f = '0;
        if (v == 0.0) begin
            return f;
        end
        f.sign = (v < 0.0);
        m = (v < 0.0) ? -v : v;
        e = 0;
        while (m >= 1.0) begin
            m = m / 2.0;
            e++;
        end
        while (m < 0.5) begin
            m = m * 2.0;
            e--;
        end
        f.exp  = 8'(e);
        f.frac = 18'($rtoi(m * 262144.0));
        return f;
    endfunction

    task automatic send_point(input int idx, input int tag, input int gap);
        repeat (gap) begin
            @(negedge iCLK);
            in_valid = 1'b0;
        end
        @(negedge iCLK);
        in_valid     = 1'b1;
        in_point.tag = `TAG_W'(tag);
        in_point.cx  = to_fp27(test_cx[idx]);
        in_point.cy  = to_fp27(test_cy[idx]);
        while (!in_ready) begin
            @(negedge iCLK);
        end
    endtask

    // Keeps the output stalled long enough to fill the queue, iterator and intake.
    task automatic hold_until_full();
        repeat (300) @(negedge iCLK);
        if (in_ready !== 1'b0) begin
            $display("[ERROR] in_ready expected %h got %h with the output stalled",
                     1'b0, in_ready);
            other_errors++;
        end
        stall_mode = 1;
    endtask

    // The output side is always ready, randomly stalled or held low.
    always @(negedge iCLK) begin
        if (stall_mode == 1) begin
            stall_rng = xorshift32(stall_rng);
            out_ready = (stall_rng[1:0] != 2'b00);
        end else begin
            out_ready = (stall_mode == 0);
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge iCLK);
        $display("timeout: results still missing");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int k;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_point     = '0;
        out_ready    = 1'b0;
        stall_mode   = 0;
        other_errors = 0;
        rng          = 32'd44;
        stall_rng    = xorshift32(32'd44);
        repeat (3) @(posedge iCLK);
        @(negedge iCLK);
        reset = 1'b0;
        @(negedge iCLK);
        if (out_valid !== 1'b0) begin
            $display("[ERROR] out_valid expected %h got %h after reset", 1'b0, out_valid);
            other_errors++;
        end
        if (in_ready !== 1'b1) begin
            $display("[ERROR] in_ready expected %h got %h after reset", 1'b1, in_ready);
            other_errors++;
        end
        // Random spacing between points.
        for (k = 0; k < num_tests; k++) begin
            rng = xorshift32(rng);
            send_point(k, k, int'(rng[2:0]));
        end
        // Back to back with in_valid held high.
        for (k = 0; k < num_tests; k++) begin
            send_point(k, 32 + k, 0);
        end
        @(negedge iCLK);
        in_valid = 1'b0;
        while (results < 2 * num_tests) begin
            @(negedge iCLK);
        end
        // Fast points against a stalled and then randomly stalling output.
        stall_mode = 2;
        fork
            for (k = 0; k < 10; k++) begin
                send_point(3 + k % 6, 64 + k, 0);
            end
            hold_until_full();
        join
        @(negedge iCLK);
        in_valid = 1'b0;
        while (results < num_points) begin
            @(negedge iCLK);
        end
        repeat (20) @(negedge iCLK);
        total_errors = mismatches + other_errors + dut0.props0.failures;
        $display("done: %0d results, %0d mismatches, %0d other errors, %0d assertion failures",
                 results, mismatches, other_errors, dut0.props0.failures);
        if (total_errors == 0 && results == num_points) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: mandel_engine.f
+incdir+verilog
verilog/fractal_pkg.sv
verilog/fp_add.sv
verilog/fp_mult.sv
verilog/point_intake.sv
verilog/escape_iterator.sv
verilog/result_queue.sv
verilog/mandel_engine.sv
verification/mandel_properties.sv
verification/mandel_checker.sv
verification/mandel_tb.sv

// File: Makefile
# Verilator build and run of the Mandelbrot engine testbench.

VERILATOR  ?= verilator
TOP        ?= mandel_tb
FILELIST   ?= mandel_engine.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= RESULT: PASS
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_ARGS   ?= +verilator+error+limit+100
SOURCES    := $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
